//--- hw/fpAdd_defs.svh
`ifndef FP_ADD_DEFS_SVH
`define FP_ADD_DEFS_SVH

// single precision field widths
`define EXP_W 8
`define FRAC_W 23

// zero bits kept below the fraction while aligning
`define GUARD_W 3

// hidden bit + fraction + guard bits
`define SIG_W (1 + `FRAC_W + `GUARD_W)

// exponent code reserved for infinity
`define EXP_MAX 255

// leading zero count, wide enough for SIG_W - 1
`define LZ_W 5

`endif

//--- hw/fpAddPkg.sv
`include "fpAdd_defs.svh"

package fpAddPkg;

  ////////////////////
  // float word layout
  ////////////////////

  // ieee 754 single, msb first
  typedef struct packed {
    logic              sign;
    logic [`EXP_W-1:0]  exponent;
    logic [`FRAC_W-1:0] fraction;
  } floatFieldsT;

  // same 32 bits seen two ways
  // raw word for transport and compare
  // field view for decode and pack
  typedef union packed {
    logic [31:0] bits;
    floatFieldsT fields;
  } floatWordT;

endpackage

//--- hw/fpLeadZero.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpLeadZero (
  input  logic [`SIG_W-1:0] value,
  output logic [`LZ_W-1:0]  count
);

  // priority encoder, highest set bit wins
  // scan upward so the last hit is the leading one
  always_comb begin
    count = '0;
    for (int i = 0; i < `SIG_W; i++) begin
      if (value[i]) begin
        // zeros sitting above bit i
        count = `LZ_W'(`SIG_W - 1 - i);
      end
    end
  end

  // all-zero value leaves count at 0
  // caller ignores it then, the zero flag takes over

endmodule

//--- hw/fpAlign.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpAlign import fpAddPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  floatWordT         a,
  input  floatWordT         b,
  output logic              alignValid,
  output logic              alignSign,
  output logic              alignSub,
  output logic [`EXP_W-1:0] alignExp,
  output logic [`SIG_W-1:0] alignBig,
  output logic [`SIG_W-1:0] alignSmall
);

  ////////////////////
  // operand decode
  ////////////////////

  logic [`EXP_W-1:0] expA;
  logic [`EXP_W-1:0] expB;
  logic [`SIG_W-1:0] sigA;
  logic [`SIG_W-1:0] sigB;

  assign expA = a.fields.exponent;
  assign expB = b.fields.exponent;

  // exponent 0 means zero or denormal, both flushed to zero
  // otherwise hidden one, fraction, then guard bits
  assign sigA = (expA == '0) ? '0 : {1'b1, a.fields.fraction, {`GUARD_W{1'b0}}};
  assign sigB = (expB == '0) ? '0 : {1'b1, b.fields.fraction, {`GUARD_W{1'b0}}};

  ////////////////////
  // magnitude order
  ////////////////////

  logic              aIsBig;
  logic              bigSign;
  logic [`EXP_W-1:0] bigExp;
  logic [`EXP_W-1:0] smallExp;
  logic [`EXP_W-1:0] expDiff;
  logic [`SIG_W-1:0] bigSig;
  logic [`SIG_W-1:0] smallSig;
  logic [`SIG_W-1:0] shiftedSig;

  // larger exponent wins, fraction breaks a tie
  // on a full tie a is taken, sign then only matters for x + x
  assign aIsBig = (expA > expB) ||
                  ((expA == expB) && (a.fields.fraction >= b.fields.fraction));

  assign bigSign  = aIsBig ? a.fields.sign : b.fields.sign;
  assign bigExp   = aIsBig ? expA : expB;
  assign smallExp = aIsBig ? expB : expA;
  assign bigSig   = aIsBig ? sigA : sigB;
  assign smallSig = aIsBig ? sigB : sigA;

  // never negative, bigExp >= smallExp
  assign expDiff = bigExp - smallExp;

  // shifted out bits dropped, gap past the significand clears it
  assign shiftedSig = (expDiff >= `SIG_W) ? '0 : (smallSig >> expDiff);

  ////////////////////
  // stage register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      alignValid <= 1'b0;
    end else begin
      alignValid <= en;
    end
  end

  // payload only moves with a new operand pair
  always_ff @(posedge clk) begin
    if (en) begin
      alignSign  <= bigSign;
      // differing signs turn the add into a subtract
      alignSub   <= a.fields.sign ^ b.fields.sign;
      alignExp   <= bigExp;
      alignBig   <= bigSig;
      alignSmall <= shiftedSig;
    end
  end

endmodule

//--- hw/fpSigAdd.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpSigAdd (
  input  logic              clk,
  input  logic              reset,
  input  logic              alignValid,
  input  logic              alignSign,
  input  logic              alignSub,
  input  logic [`EXP_W-1:0] alignExp,
  input  logic [`SIG_W-1:0] alignBig,
  input  logic [`SIG_W-1:0] alignSmall,
  output logic              sumValid,
  output logic              sumSign,
  output logic              sumZero,
  output logic [`EXP_W-1:0] sumExp,
  output logic [`SIG_W:0]   sumSig
);

  // one extra bit at the top catches the carry
  logic [`SIG_W:0] sigSum;
  logic            sigZero;

  // big >= small, so the difference stays non-negative
  assign sigSum = alignSub ? ({1'b0, alignBig} - {1'b0, alignSmall})
                           : ({1'b0, alignBig} + {1'b0, alignSmall});

  // exact cancellation or two zero operands
  assign sigZero = (sigSum == '0);

  ////////////////////
  // stage register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      sumValid <= 1'b0;
    end else begin
      sumValid <= alignValid;
    end
  end

  always_ff @(posedge clk) begin
    if (alignValid) begin
      sumSign <= alignSign;
      sumExp  <= alignExp;
      sumSig  <= sigSum;
      sumZero <= sigZero;
    end
  end

endmodule

//--- hw/fpNormalize.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpNormalize import fpAddPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              sumValid,
  input  logic              sumSign,
  input  logic              sumZero,
  input  logic [`EXP_W-1:0] sumExp,
  input  logic [`SIG_W:0]   sumSig,
  output floatWordT         y,
  output logic              done
);

  ////////////////////
  // leading one search
  ////////////////////

  logic [`LZ_W-1:0] lzCount;

  // carry bit handled apart, only the low bits searched
  fpLeadZero u_leadZero (
    .value (sumSig[`SIG_W-1:0]),
    .count (lzCount)
  );

  ////////////////////
  // shift and exponent
  ////////////////////

  logic                   carry;
  logic [`SIG_W-1:0]      normSig;
  logic signed [`EXP_W:0] resExp;
  logic                   expOver;
  logic                   expUnder;

  assign carry = sumSig[`SIG_W];

  // carry: one right, else left until the leading one sits at the top
  assign normSig = carry ? sumSig[`SIG_W:1] : (sumSig[`SIG_W-1:0] << lzCount);

  // one bit wider and signed, room for 255 and for values below zero
  assign resExp = carry
    ? $signed({1'b0, sumExp}) + $signed((`EXP_W+1)'(1))
    : $signed({1'b0, sumExp}) - $signed({{(`EXP_W+1-`LZ_W){1'b0}}, lzCount});

  assign expOver  = (resExp >= `EXP_MAX);
  assign expUnder = (resExp <= 0);

  ////////////////////
  // result packing
  ////////////////////

  floatWordT res;

  always_comb begin
    res.fields.sign     = sumSign;
    res.fields.exponent = resExp[`EXP_W-1:0];
    // 23 bits under the leading one, guard bits truncated
    res.fields.fraction = normSig[`SIG_W-2 -: `FRAC_W];
    if (sumZero) begin
      // cancellation always gives +0
      res.bits = '0;
    end else if (expOver) begin
      // signed infinity
      res.fields.exponent = `EXP_W'(`EXP_MAX);
      res.fields.fraction = '0;
    end else if (expUnder) begin
      // flush to signed zero
      res.fields.exponent = '0;
      res.fields.fraction = '0;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= sumValid;
    end
  end

  // y held until the next result lands
  always_ff @(posedge clk) begin
    if (sumValid) begin
      y <= res;
    end
  end

endmodule

//--- hw/fpAdd.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpAdd import fpAddPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      en,
  input  floatWordT a,
  input  floatWordT b,
  output floatWordT y,
  output logic      done
);

  // align to add
  logic              alignValid;
  logic              alignSign;
  logic              alignSub;
  logic [`EXP_W-1:0] alignExp;
  logic [`SIG_W-1:0] alignBig;
  logic [`SIG_W-1:0] alignSmall;

  // add to normalise
  logic              sumValid;
  logic              sumSign;
  logic              sumZero;
  logic [`EXP_W-1:0] sumExp;
  logic [`SIG_W:0]   sumSig;

  ////////////////////
  // compare and shift
  ////////////////////

  fpAlign u_align (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .a          (a),
    .b          (b),
    .alignValid (alignValid),
    .alignSign  (alignSign),
    .alignSub   (alignSub),
    .alignExp   (alignExp),
    .alignBig   (alignBig),
    .alignSmall (alignSmall)
  );

  ////////////////////
  // significand add
  ////////////////////

  fpSigAdd u_sigAdd (
    .clk        (clk),
    .reset      (reset),
    .alignValid (alignValid),
    .alignSign  (alignSign),
    .alignSub   (alignSub),
    .alignExp   (alignExp),
    .alignBig   (alignBig),
    .alignSmall (alignSmall),
    .sumValid   (sumValid),
    .sumSign    (sumSign),
    .sumZero    (sumZero),
    .sumExp     (sumExp),
    .sumSig     (sumSig)
  );

  ////////////////////
  // normalise and pack
  ////////////////////

  fpNormalize u_normalize (
    .clk      (clk),
    .reset    (reset),
    .sumValid (sumValid),
    .sumSign  (sumSign),
    .sumZero  (sumZero),
    .sumExp   (sumExp),
    .sumSig   (sumSig),
    .y        (y),
    .done     (done)
  );

endmodule

//--- sim/fpAddTb.sv
`timescale 1ns/1ps
`include "fpAdd_defs.svh"

module fpAddTb import fpAddPkg::*; ();

  // falling edges from the en drive point to the one where done shows
  localparam int LATENCY = 3;
  // idle cycles allowed while waiting for the last results
  localparam int DRAIN_LIMIT = 20;

  logic      clk = 1'b0;
  logic      reset;
  logic      en;
  floatWordT a;
  floatWordT b;
  floatWordT y;
  logic      done;

  int          edgeCount = 0;
  logic [31:0] lfsrState = 32'h4f155473;
  int          checkCount = 0;
  int          errorCount = 0;
  int          errorsAtStart = 0;
  int          testCount = 0;
  int          testFails = 0;

  // drive edge and expected word for each pair in issue order
  int        pendEdge[$];
  floatWordT pendWord[$];

  fpAdd u_dut (
    .clk   (clk),
    .reset (reset),
    .en    (en),
    .a     (a),
    .b     (b),
    .y     (y),
    .done  (done)
  );

  ////////////////////
  // clock
  ////////////////////

  initial begin
    forever #50 clk = ~clk;
  end

  // rising edges seen so far
  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  ////////////////////
  // random numbers
  ////////////////////

  // taps for x^32 + x^22 + x^2 + x + 1
  // new bit enters at the lsb
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic int randRange(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'(randBits(16) % span);
  endfunction

  function automatic floatWordT makeFloat(input logic sign, input int exp,
                                          input logic [31:0] frac);
    floatWordT w;
    w.fields.sign     = sign;
    w.fields.exponent = `EXP_W'(exp);
    w.fields.fraction = `FRAC_W'(frac);
    return w;
  endfunction

  function automatic floatWordT randFloat(input logic sign, input int lo, input int hi);
    return makeFloat(sign, randRange(lo, hi), randBits(`FRAC_W));
  endfunction

  // half far away and half within two of e
  // close exponents make carries common
  function automatic int partnerExp(input int e);
    int p;
    if (randBits(1) == 32'd1) begin
      p = randRange(1, 254);
    end else begin
      p = e + randRange(-2, 2);
    end
    if (p < 1) begin
      p = 1;
    end
    if (p > 254) begin
      p = 254;
    end
    return p;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic floatWordT addModel(input floatWordT opA, input floatWordT opB);
    int          expA;
    int          expB;
    int          bigExp;
    int          gap;
    int          resExp;
    logic [31:0] sigA;
    logic [31:0] sigB;
    logic [31:0] bigSig;
    logic [31:0] smallSig;
    logic [31:0] sum;
    logic        bigSign;
    floatWordT   r;
    expA = int'(opA.fields.exponent);
    expB = int'(opB.fields.exponent);
    // exponent 0 reads as zero whatever the fraction holds
    sigA = (expA == 0) ? 32'd0
                       : ((32'(opA.fields.fraction) | (32'd1 << `FRAC_W)) << `GUARD_W);
    sigB = (expB == 0) ? 32'd0
                       : ((32'(opB.fields.fraction) | (32'd1 << `FRAC_W)) << `GUARD_W);
    // bigger exponent wins and bigger fraction breaks a tie
    if (expA > expB || (expA == expB && opA.fields.fraction >= opB.fields.fraction)) begin
      bigSig   = sigA;
      smallSig = sigB;
      bigExp   = expA;
      gap      = expA - expB;
      bigSign  = opA.fields.sign;
    end else begin
      bigSig   = sigB;
      smallSig = sigA;
      bigExp   = expB;
      gap      = expB - expA;
      bigSign  = opB.fields.sign;
    end
    if (gap >= `SIG_W) begin
      smallSig = 32'd0;
    end else begin
      smallSig = smallSig >> gap;
    end
    sum = (opA.fields.sign != opB.fields.sign) ? bigSig - smallSig : bigSig + smallSig;
    // zero sum stays +0
    r.bits = '0;
    if (sum != 32'd0) begin
      resExp = bigExp;
      if (sum >= (32'd1 << `SIG_W)) begin
        sum    = sum >> 1;
        resExp = resExp + 1;
      end
      while (sum < (32'd1 << (`SIG_W - 1))) begin
        sum    = sum << 1;
        resExp = resExp - 1;
      end
      r.fields.sign = bigSign;
      if (resExp >= `EXP_MAX) begin
        r.fields.exponent = `EXP_W'(`EXP_MAX);
      end else if (resExp > 0) begin
        r.fields.exponent = `EXP_W'(resExp);
        r.fields.fraction = `FRAC_W'(sum >> `GUARD_W);
      end
      // exponent 0 or below leaves signed zero
    end
    return r;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic checkWord(input string name, input floatWordT expected,
                           input floatWordT actual);
    checkCount++;
    if (actual.bits !== expected.bits) begin
      errorCount++;
      $display("error at %0d ns: %s expected %h, got %h",
               $time, name, expected.bits, actual.bits);
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  ////////////////////
  // cycle driver
  ////////////////////

  // check what the last edge produced, then drive the next inputs
  task automatic stepCycle(input logic issue, input floatWordT opA, input floatWordT opB);
    logic      expectDone;
    floatWordT expectWord;
    @(negedge clk);
    expectDone = (pendEdge.size() > 0) && (pendEdge[0] + LATENCY == edgeCount);
    checkBit("done", expectDone, done);
    // popped when due even if done missed
    // keeps the queue moving
    if (expectDone) begin
      expectWord = pendWord.pop_front();
      pendEdge.delete(0);
      if (done) begin
        checkWord("y", expectWord, y);
      end
    end
    en = issue;
    a  = opA;
    b  = opB;
    if (issue) begin
      pendEdge.push_back(edgeCount);
      pendWord.push_back(addModel(opA, opB));
    end
  endtask

  task automatic issuePair(input floatWordT opA, input floatWordT opB);
    // operand order picked at random
    if (randBits(1) == 32'd1) begin
      stepCycle(1'b1, opB, opA);
    end else begin
      stepCycle(1'b1, opA, opB);
    end
  endtask

  task automatic waitDrain(input string testName);
    int waited;
    waited = 0;
    while (pendEdge.size() > 0 && waited < DRAIN_LIMIT) begin
      stepCycle(1'b0, '0, '0);
      waited++;
    end
    if (pendEdge.size() > 0) begin
      errorCount++;
      $display("timeout in %s: %0d results never came out", testName, pendEdge.size());
      pendEdge.delete();
      pendWord.delete();
    end
  endtask

  task automatic beginTest();
    errorsAtStart = errorCount;
  endtask

  task automatic endTest(input string name);
    waitDrain(name);
    // quiet cycles catch a stray or repeated done
    repeat (4) stepCycle(1'b0, '0, '0);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %s: ok", name);
    end else begin
      testFails++;
      $display("test %s: %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  // operands toggle while en stays low
  task automatic idleAfterReset();
    beginTest();
    repeat (10) stepCycle(1'b0, randFloat(1'b0, 1, 254), randFloat(1'b1, 1, 254));
    endTest("idle after reset");
  endtask

  task automatic zeroOperands();
    floatWordT x;
    floatWordT posZero;
    floatWordT negZero;
    floatWordT denorm;
    beginTest();
    posZero = makeFloat(1'b0, 0, 32'd0);
    negZero = makeFloat(1'b1, 0, 32'd0);
    for (int i = 0; i < 8; i++) begin
      x = randFloat(1'(randBits(1)), 1, 254);
      denorm = makeFloat(1'(randBits(1)), 0, randBits(`FRAC_W) | 32'd1);
      issuePair(x, posZero);
      issuePair(x, negZero);
      issuePair(x, denorm);
      issuePair(posZero, negZero);
      issuePair(negZero, negZero);
      // exact cancellation
      issuePair(x, makeFloat(~x.fields.sign, int'(x.fields.exponent),
                             32'(x.fields.fraction)));
    end
    endTest("zero operands");
  endtask

  task automatic sameSignSums();
    logic      s;
    floatWordT opA;
    beginTest();
    for (int i = 0; i < 200; i++) begin
      s   = 1'(randBits(1));
      opA = randFloat(s, 1, 254);
      issuePair(opA, makeFloat(s, partnerExp(int'(opA.fields.exponent)),
                               randBits(`FRAC_W)));
    end
    endTest("same sign");
  endtask

  task automatic oppositeSignSums();
    logic      s;
    int        e;
    floatWordT opA;
    floatWordT opB;
    beginTest();
    for (int i = 0; i < 210; i++) begin
      s = 1'(randBits(1));
      if (i % 3 == 0) begin
        opA = randFloat(s, 1, 254);
        opB = makeFloat(~s, partnerExp(int'(opA.fields.exponent)), randBits(`FRAC_W));
      end else if (i % 3 == 1) begin
        // near-equal magnitudes need a long left shift
        opA = randFloat(s, 30, 254);
        opB = makeFloat(~s, int'(opA.fields.exponent),
                        32'(opA.fields.fraction) ^ randBits(randRange(1, 12)));
      end else begin
        // smaller operand vanishes across a gap of SIG_W or more
        e   = randRange(70, 254);
        opA = randFloat(s, e, e);
        opB = randFloat(~s, e - randRange(`SIG_W, `SIG_W + 40), e - `SIG_W);
      end
      issuePair(opA, opB);
    end
    endTest("opposite sign");
  endtask

  task automatic rangeLimits();
    logic      s;
    floatWordT opA;
    beginTest();
    for (int i = 0; i < 40; i++) begin
      s = 1'(randBits(1));
      // carry out of exponent 254 gives infinity
      issuePair(randFloat(s, 254, 254), randFloat(s, 250, 254));
      // cancellation near exponent 1 drops below the normal range
      opA = randFloat(s, 1, 4);
      issuePair(opA, makeFloat(~s, int'(opA.fields.exponent),
                               32'(opA.fields.fraction) ^ randBits(randRange(1, 20))));
    end
    endTest("overflow and underflow");
  endtask

  task automatic backToBack();
    floatWordT opA;
    for (int i = 0; i < 300; i++) begin
      opA = randFloat(1'(randBits(1)), 1, 254);
      if (randBits(2) != 32'd0) begin
        issuePair(opA, makeFloat(1'(randBits(1)), partnerExp(int'(opA.fields.exponent)),
                                 randBits(`FRAC_W)));
      end else begin
        stepCycle(1'b0, opA, randFloat(1'b1, 1, 254));
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    reset = 1'b1;
    en    = 1'b0;
    a     = '0;
    b     = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    idleAfterReset();
    zeroOperands();
    sameSignSums();
    oppositeSignSums();
    rangeLimits();
    beginTest();
    backToBack();
    endTest("back to back with gaps");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, testFails, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hw
hw/fpAddPkg.sv
hw/fpLeadZero.sv
hw/fpAlign.sv
hw/fpSigAdd.sv
hw/fpNormalize.sv
hw/fpAdd.sv
sim/fpAddTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary -j 0 -Wno-fatal
TOP      = fpAddTb
FLIST    = flist.f
OBJ_DIR  = obj_dir
PASS_MSG = Result: PASSED

SRCS := $(shell grep -v '^+' $(FLIST)) hw/fpAdd_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
